/* hw/dcache_pkg.sv */
// Data cache shared types
package dcache_pkg;

    // Geometry, fixed at four ways by the tree replacement logic
    localparam int WORD_W    = 32;
    localparam int NUM_BYTES = 4;   // Also the byte enable width
    localparam int NUM_WAYS  = 4;
    localparam int WAY_W     = 2;
    localparam int NUM_SETS  = 8;
    localparam int SET_W     = 3;
    localparam int OFF_W     = 2;   // Byte offset, ignored by the cache
    localparam int TAG_W     = WORD_W - SET_W - OFF_W;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [NUM_BYTES-1:0] byte_en_t;
    typedef logic [SET_W-1:0]     set_idx_t;
    typedef logic [WAY_W-1:0]     way_idx_t;
    typedef logic [NUM_WAYS-1:0]  way_mask_t;  // One bit per way
    typedef logic [TAG_W-1:0]     tag_t;

    // Word address split, MSB first so a flat address casts straight on
    typedef struct packed {
        tag_t              tag;
        set_idx_t          set;
        logic [OFF_W-1:0]  offset;
    } addr_t;

    // Request opcode
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } req_op_e;

    // Processor request, held while stall is high
    typedef struct packed {
        req_op_e   op;
        addr_t     addr;
        word_t     wdata;
        byte_en_t  byte_en;
    } cpu_req_t;

    // Memory fill strobe, one cycle wide
    typedef struct packed {
        logic   valid;
        word_t  data;
    } mem_fill_t;

endpackage

/* hw/dcache_tag_array.sv */
// Cache tag and valid store
module dcache_tag_array (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::set_idx_t set_idx,
    input  dcache_pkg::tag_t     tag,
    input  logic                 alloc_en,
    input  dcache_pkg::way_idx_t alloc_way,
    output logic                 hit,
    output dcache_pkg::way_idx_t hit_way,
    output logic                 all_valid,
    output dcache_pkg::way_idx_t free_way
);
    import dcache_pkg::*;

    tag_t      tags_q  [NUM_SETS][NUM_WAYS];   // Tag per set and way
    way_mask_t valid_q [NUM_SETS];             // Valid bits, one per way

    way_mask_t hit_mask;   // One-hot when the set holds the tag
    way_mask_t set_valid;  // Valid bits of the addressed set

    assign set_valid = valid_q[set_idx];
    assign all_valid = &set_valid;
    assign hit       = |hit_mask;

    // Compare every way of the addressed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_mask[w] = set_valid[w] && (tags_q[set_idx][w] == tag);
        end
    end

    // One-hot to index, zero when nothing hits
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_mask[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    // Lowest invalid way wins, so scan from the top down
    always_comb begin
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                free_way = way_idx_t'(w);
            end
        end
    end

    // Valid bits are control state and clear on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (alloc_en) begin
            valid_q[set_idx][alloc_way] <= 1'b1;  // Line now owned by new tag
        end
    end

    // Tag storage, only meaningful behind a valid bit
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            tags_q[set_idx][alloc_way] <= tag;
        end
    end

endmodule

/* hw/dcache_data_array.sv */
// Cache data word store
module dcache_data_array (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::set_idx_t set_idx,
    input  dcache_pkg::way_idx_t rd_way,
    output dcache_pkg::word_t    line_word,
    input  logic                 wr_en,
    input  dcache_pkg::way_idx_t wr_way,
    input  dcache_pkg::word_t    wr_word
);
    import dcache_pkg::*;

    // One word per line, sets by ways
    word_t data_q [NUM_SETS][NUM_WAYS];

    // Combinational read of the selected way
    assign line_word = data_q[set_idx][rd_way];

    // Single full-word write port
    // Byte merging happens upstream in the controller
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    data_q[s][w] <= '0;  // Whole store starts at zero
                end
            end
        end else if (wr_en) begin
            data_q[set_idx][wr_way] <= wr_word;
        end
    end

endmodule

/* hw/dcache_plru.sv */
// Tree pseudo-LRU replacement
module dcache_plru (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::set_idx_t set_idx,
    input  logic                 touch_en,
    input  dcache_pkg::way_idx_t touch_way,
    output dcache_pkg::way_idx_t lru_way
);
    import dcache_pkg::*;

    // Three bits per set
    // root_q: 1 when the high half (ways 2,3) was touched last
    // leaf_q[h]: 1 when the odd way of half h was touched last
    logic       root_q [NUM_SETS];
    logic [1:0] leaf_q [NUM_SETS];

    logic       root;
    logic [1:0] leaf;
    logic       victim_half;  // Half not touched last
    logic       victim_odd;   // Way within that half not touched last

    assign root = root_q[set_idx];
    assign leaf = leaf_q[set_idx];

    // Walk the tree away from the most recent path
    always_comb begin
        victim_half = ~root;
        victim_odd  = ~leaf[victim_half];
        lru_way     = {victim_half, victim_odd};
    end

    // Touch points both levels at the used way
    // The other half's leaf keeps its history
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                root_q[s] <= 1'b0;
                leaf_q[s] <= 2'b00;
            end
        end else if (touch_en) begin
            root_q[set_idx]               <= touch_way[1];  // Record the half
            leaf_q[set_idx][touch_way[1]] <= touch_way[0];  // Record the way in it
        end
    end

endmodule

/* hw/dcache_ctrl.sv */
// Data cache controller
module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::cpu_req_t  cpu_req,
    input  dcache_pkg::mem_fill_t fill,
    input  logic                  hit,
    input  dcache_pkg::way_idx_t  hit_way,
    input  logic                  all_valid,
    input  dcache_pkg::way_idx_t  free_way,
    input  dcache_pkg::way_idx_t  lru_way,
    input  dcache_pkg::word_t     line_word,
    output dcache_pkg::set_idx_t  set_idx,
    output dcache_pkg::tag_t      tag,
    output dcache_pkg::way_idx_t  rd_way,
    output logic                  alloc_en,
    output dcache_pkg::way_idx_t  alloc_way,
    output logic                  wr_en,
    output dcache_pkg::way_idx_t  wr_way,
    output dcache_pkg::word_t     wr_word,
    output logic                  touch_en,
    output dcache_pkg::way_idx_t  touch_way,
    output dcache_pkg::word_t     rdata,
    output logic                  stall
);
    import dcache_pkg::*;

    logic     is_rd;
    logic     is_wr;
    logic     full_wr;   // Write covering all four bytes
    logic     miss;
    logic     do_alloc;  // Miss resolved this cycle
    way_idx_t victim;
    word_t    rd_q;      // Registered read word

    // Enabled bytes of wdata over a base word
    function automatic word_t merge_bytes(word_t base, word_t wdata, byte_en_t be);
        word_t res;
        for (int b = 0; b < NUM_BYTES; b++) begin
            res[8*b +: 8] = be[b] ? wdata[8*b +: 8] : base[8*b +: 8];
        end
        return res;
    endfunction

    assign set_idx = cpu_req.addr.set;
    assign tag     = cpu_req.addr.tag;
    assign rd_way  = hit_way;  // Data array reads the hitting way

    assign is_rd   = (cpu_req.op == OP_READ);
    assign is_wr   = (cpu_req.op == OP_WRITE);
    assign full_wr = is_wr && (&cpu_req.byte_en);
    assign miss    = (is_rd || is_wr) && !hit;

    // Full-word write miss allocates straight away, everything else waits
    assign stall    = miss && !full_wr;
    assign do_alloc = miss && (fill.valid || full_wr);
    assign victim   = all_valid ? lru_way : free_way;  // Invalid ways first

    always_comb begin
        alloc_en  = 1'b0;
        alloc_way = victim;
        wr_en     = 1'b0;
        wr_way    = hit_way;
        wr_word   = merge_bytes(line_word, cpu_req.wdata, cpu_req.byte_en);
        touch_en  = 1'b0;
        touch_way = hit_way;
        if ((is_rd || is_wr) && hit) begin
            touch_en = 1'b1;
            wr_en    = is_wr;  // Read hit leaves the store alone
        end else if (do_alloc) begin
            alloc_en  = 1'b1;
            wr_en     = 1'b1;
            wr_way    = victim;
            touch_way = victim;
            touch_en  = 1'b1;
            // Full-word write ignores fill.data since every byte is enabled
            wr_word   = is_rd ? fill.data
                              : merge_bytes(fill.data, cpu_req.wdata, cpu_req.byte_en);
        end
    end

    // Read register, loads on a read hit
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q <= '0;
        end else if (is_rd && hit) begin
            rd_q <= line_word;
        end
    end

    assign rdata = fill.valid ? fill.data : rd_q;  // Fill word bypass

endmodule

/* hw/dcache_top.sv */
// Data cache top level
module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::cpu_req_t  cpu_req,
    input  dcache_pkg::mem_fill_t fill,
    output dcache_pkg::word_t     rdata,
    output logic                  stall
);
    import dcache_pkg::*;

    set_idx_t set_idx;
    tag_t     tag;
    logic     hit;
    way_idx_t hit_way;
    logic     all_valid;
    way_idx_t free_way;
    way_idx_t lru_way;
    way_idx_t rd_way;
    word_t    line_word;
    logic     alloc_en;
    way_idx_t alloc_way;
    logic     wr_en;
    way_idx_t wr_way;
    word_t    wr_word;
    logic     touch_en;
    way_idx_t touch_way;

    // Hit/miss decision and datapath muxing
    dcache_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .fill      (fill),
        .hit       (hit),
        .hit_way   (hit_way),
        .all_valid (all_valid),
        .free_way  (free_way),
        .lru_way   (lru_way),
        .line_word (line_word),
        .set_idx   (set_idx),
        .tag       (tag),
        .rd_way    (rd_way),
        .alloc_en  (alloc_en),
        .alloc_way (alloc_way),
        .wr_en     (wr_en),
        .wr_way    (wr_way),
        .wr_word   (wr_word),
        .touch_en  (touch_en),
        .touch_way (touch_way),
        .rdata     (rdata),
        .stall     (stall)
    );

    dcache_tag_array i_tag_array (
        .clk       (clk),
        .rst       (rst),
        .set_idx   (set_idx),
        .tag       (tag),
        .alloc_en  (alloc_en),
        .alloc_way (alloc_way),
        .hit       (hit),
        .hit_way   (hit_way),
        .all_valid (all_valid),
        .free_way  (free_way)
    );

    dcache_data_array i_data_array (
        .clk       (clk),
        .rst       (rst),
        .set_idx   (set_idx),
        .rd_way    (rd_way),
        .line_word (line_word),
        .wr_en     (wr_en),
        .wr_way    (wr_way),
        .wr_word   (wr_word)
    );

    // Replacement state, same set index as the lookup
    dcache_plru i_plru (
        .clk       (clk),
        .rst       (rst),
        .set_idx   (set_idx),
        .touch_en  (touch_en),
        .touch_way (touch_way),
        .lru_way   (lru_way)
    );

endmodule

/* tb/tb_clock_gen.sv */
// Testbench clock and reset
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD_NS = 4;  // 8 ns clock
    localparam int RESET_CYCLES   = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    // Reset high through the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb/tb_dcache.sv */
// Data cache testbench
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    localparam int    CLK_PERIOD_NS = 8;
    localparam string VECTOR_FILE   = "tb/dcache_vectors.txt";

    logic      clk;
    logic      rst;
    cpu_req_t  cpu_req;
    mem_fill_t fill;
    word_t     rdata;
    logic      stall;

    // One entry per vector line
    string     names_q [$];
    cpu_req_t  reqs_q  [$];
    word_t     fills_q [$];
    int        delays_q[$];   // Cycles before the fill strobe
    logic      miss_q  [$];   // Stall expected
    logic      chk_q   [$];   // Read word to be checked
    word_t     exp_q   [$];

    int   check_fails = 0;
    int   pass_cnt    = 0;
    int   fail_cnt    = 0;
    int   bad_lines   = 0;
    int   max_delay   = 0;
    int   limit_ns    = 0;
    logic loaded      = 1'b0;  // Watchdog starts once the length is known

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    dcache_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .fill    (fill),
        .rdata   (rdata),
        .stall   (stall)
    );

    task automatic check_stall(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected stall %0b, got %0b", name, exp, act);
            check_fails++;
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected rdata %08h, got %08h", name, exp, act);
            check_fails++;
        end
    endtask

    // Vector file parser that skips comments and blank lines
    task automatic load_vectors();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        string       name;
        string       exp_s;
        logic [31:0] op_v;
        logic [31:0] addr_v;
        logic [31:0] wdata_v;
        logic [31:0] be_v;
        logic [31:0] fill_v;
        logic [31:0] exp_v;
        int          delay_v;
        int          miss_v;
        cpu_req_t    req;
        fd = $fopen(VECTOR_FILE, "r");
        line_no = 0;
        if (fd == 0) begin
            $display("Could not open the vector file %s", VECTOR_FILE);
            bad_lines++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            line_no++;
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%s %h %h %h %h %h %d %d %s", name, op_v, addr_v,
                        wdata_v, be_v, fill_v, delay_v, miss_v, exp_s);
            if (n != 9) begin
                $display("Vector line %0d is malformed and was skipped", line_no);
                bad_lines++;
                continue;
            end
            req.op      = req_op_e'(op_v[1:0]);
            req.addr    = addr_t'(addr_v);   // Flat address onto tag/set/offset
            req.wdata   = wdata_v;
            req.byte_en = be_v[NUM_BYTES-1:0];
            names_q.push_back(name);
            reqs_q.push_back(req);
            fills_q.push_back(fill_v);
            delays_q.push_back(delay_v);
            miss_q.push_back(miss_v != 0);
            if (exp_s == "-") begin
                chk_q.push_back(1'b0);
                exp_q.push_back('0);
            end else begin
                n = $sscanf(exp_s, "%h", exp_v);
                chk_q.push_back(1'b1);
                exp_q.push_back(exp_v);
            end
            if (delay_v > max_delay) max_delay = delay_v;
        end
        $fclose(fd);
    endtask

    // Memory model that strobes fill for one cycle after the given delay
    task automatic supply_fill(string name, word_t data, int delay);
        mem_fill_t f;
        f.valid = 1'b1;
        f.data  = data;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        fill <= f;
        @(negedge clk);
        check_word(name, data, rdata);  // Fill word bypassed to rdata
        @(posedge clk);
        fill <= '0;   // Line allocated at this edge
    endtask

    // Present one request and follow it to completion
    task automatic run_vector(int i);
        int   fails_before;
        logic stalled;
        fails_before = check_fails;
        stalled      = 1'b0;
        @(posedge clk);
        cpu_req <= reqs_q[i];
        @(negedge clk);
        if (stall) begin
            stalled = 1'b1;
            supply_fill(names_q[i], fills_q[i], delays_q[i]);
            @(negedge clk);
        end
        while (stall) @(negedge clk);   // Wait out any remaining stall
        @(posedge clk);                 // Completing edge
        cpu_req <= '0;
        @(negedge clk);
        check_stall(names_q[i], miss_q[i], stalled);
        if (chk_q[i]) check_word(names_q[i], exp_q[i], rdata);
        if (check_fails == fails_before) begin
            pass_cnt++;
            $display("test %s: ok", names_q[i]);
        end else begin
            fail_cnt++;
            $display("test %s: failed", names_q[i]);
        end
    endtask

    initial begin : main
        cpu_req = '0;
        fill    = '0;
        load_vectors();
        limit_ns = (reqs_q.size() * (max_delay + 4) + 20) * CLK_PERIOD_NS;
        loaded   = 1'b1;
        @(negedge rst);
        for (int i = 0; i < reqs_q.size(); i++) begin
            run_vector(i);
        end
        $display("Tests passed: %0d, failed: %0d, bad vector lines: %0d",
                 pass_cnt, fail_cnt, bad_lines);
        if (fail_cnt == 0 && bad_lines == 0 && reqs_q.size() > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #(limit_ns);
        $display("Timeout: the tests did not finish within %0d ns", limit_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* tb/dcache_vectors.txt */
# name op addr wdata byte_en fill delay miss rdata
# op 1 read, 2 write; hex fields except delay and miss; rdata "-" skips the read check
rd_cold_miss     1 00000104 00000000 0 CAFEF00D 2 1 CAFEF00D
rd_cold_hit      1 00000104 00000000 0 00000000 0 0 CAFEF00D
wr_full_miss     2 00000204 12345678 F 00000000 0 0 -
rd_after_full    1 00000204 00000000 0 00000000 0 0 12345678
wr_part_hit      2 00000104 AABBCCDD 5 00000000 0 0 -
rd_after_part    1 00000104 00000000 0 00000000 0 0 CABBF0DD
wr_part_miss     2 00000304 11223344 C 55667788 1 1 -
rd_part_merge    1 00000304 00000000 0 00000000 0 0 11227788
repl_fill_w0     1 00000020 00000000 0 11110000 0 1 11110000
repl_fill_w1     1 00000040 00000000 0 22220000 3 1 22220000
repl_fill_w2     2 00000060 33330000 F 00000000 0 0 -
repl_fill_w3     1 00000080 00000000 0 44440000 0 1 44440000
repl_touch_w0    1 00000020 00000000 0 00000000 0 0 11110000
repl_evict_w2    1 000000A0 00000000 0 55550000 1 1 55550000
repl_keep_w0     1 00000020 00000000 0 00000000 0 0 11110000
repl_keep_w1     1 00000040 00000000 0 00000000 0 0 22220000
repl_keep_w3     1 00000080 00000000 0 00000000 0 0 44440000
repl_evicted     1 00000060 00000000 0 33331111 2 1 33331111
set2_miss        1 000000E8 00000000 0 7A7A0002 0 1 7A7A0002
set3_miss        1 000000EC 00000000 0 7A7A0003 1 1 7A7A0003
set2_hit         1 000000E8 00000000 0 00000000 0 0 7A7A0002
set1_kept_a      1 00000104 00000000 0 00000000 0 0 CABBF0DD
set1_kept_b      1 00000204 00000000 0 00000000 0 0 12345678
set0_kept        1 000000A0 00000000 0 00000000 0 0 55550000
set2_wr_byte     2 000000E9 000000FF 1 00000000 0 0 -
set3_untouched   1 000000EC 00000000 0 00000000 0 0 7A7A0003
set2_rd_byte     1 000000EA 00000000 0 00000000 0 0 7A7A00FF
offset_ignored   1 00000107 00000000 0 00000000 0 0 CABBF0DD

/* dcache_top.f */
hw/dcache_pkg.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_plru.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tb/tb_clock_gen.sv
tb/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the data cache simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_dcache \
    -f dcache_top.f -o sim_dcache > build.log 2>&1 \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0
